//--- Bender.yml
package:
  name: odma_rd_arbiter

sources:
  - odma_rd_pkg.sv
  - odma_rd_req_arbiter.sv
  - odma_rd_rsp_dispatcher.sv
  - odma_rd_arbiter.sv
  - target: test
    files:
      - odma_rd_arbiter_clk_gen.sv
      - odma_rd_arbiter_checker.sv
      - odma_rd_arbiter_tb.sv

//--- list.f
odma_rd_pkg.sv
odma_rd_req_arbiter.sv
odma_rd_rsp_dispatcher.sv
odma_rd_arbiter.sv
odma_rd_arbiter_clk_gen.sv
odma_rd_arbiter_checker.sv
odma_rd_arbiter_tb.sv

//--- odma_rd_arbiter.sv
// Local read arbiter top level
// Joins the request arbiter and the response dispatcher between the
// three DMA engines and the shared local read interface

`timescale 1ns/100ps

module odma_rd_arbiter #(
    parameter int data_width = 64
) (
    input  logic                       clk,
    input  logic                       resetn,

    // Local read interface
    output logic                       lcl_rd_valid,
    output odma_rd_pkg::rd_req_t       lcl_rd_req,
    output logic [data_width/8-1:0]    lcl_rd_be,
    input  logic                       lcl_rd_ready,
    input  logic                       lcl_rd_data_valid,
    input  logic [data_width-1:0]      lcl_rd_data,
    input  odma_rd_pkg::rd_rsp_t       lcl_rd_rsp,
    output logic                       lcl_rd_rsp_ready,

    // Descriptor engine
    input  logic                       dsc_rd_valid,
    input  odma_rd_pkg::rd_req_t       dsc_rd_req,
    input  logic [data_width/8-1:0]    dsc_rd_be,
    output logic                       dsc_rd_ready,
    output logic                       dsc_rd_data_valid,
    output logic [data_width-1:0]      dsc_rd_data,
    output odma_rd_pkg::rd_rsp_t       dsc_rd_rsp,
    input  logic                       dsc_rd_rsp_ready,

    // Host-to-card MM engine
    input  logic                       mm_rd_valid,
    input  odma_rd_pkg::rd_req_t       mm_rd_req,
    input  logic [data_width/8-1:0]    mm_rd_be,
    output logic                       mm_rd_ready,
    output logic                       mm_rd_data_valid,
    output logic [data_width-1:0]      mm_rd_data,
    output odma_rd_pkg::rd_rsp_t       mm_rd_rsp,
    input  logic                       mm_rd_rsp_ready,

    // Host-to-card stream engine
    input  logic                       st_rd_valid,
    input  odma_rd_pkg::rd_req_t       st_rd_req,
    input  logic [data_width/8-1:0]    st_rd_be,
    output logic                       st_rd_ready,
    output logic                       st_rd_data_valid,
    output logic [data_width-1:0]      st_rd_data,
    output odma_rd_pkg::rd_rsp_t       st_rd_rsp,
    input  logic                       st_rd_rsp_ready
);

    // Request direction
    odma_rd_req_arbiter #(
        .data_width (data_width)
    ) req_arbiter_inst (
        .clk          (clk),
        .resetn       (resetn),
        .dsc_rd_valid (dsc_rd_valid),
        .dsc_rd_req   (dsc_rd_req),
        .dsc_rd_be    (dsc_rd_be),
        .dsc_rd_ready (dsc_rd_ready),
        .mm_rd_valid  (mm_rd_valid),
        .mm_rd_req    (mm_rd_req),
        .mm_rd_be     (mm_rd_be),
        .mm_rd_ready  (mm_rd_ready),
        .st_rd_valid  (st_rd_valid),
        .st_rd_req    (st_rd_req),
        .st_rd_be     (st_rd_be),
        .st_rd_ready  (st_rd_ready),
        .lcl_rd_valid (lcl_rd_valid),
        .lcl_rd_req   (lcl_rd_req),
        .lcl_rd_be    (lcl_rd_be),
        .lcl_rd_ready (lcl_rd_ready)
    );

    // Response direction, independent of the grant
    odma_rd_rsp_dispatcher #(
        .data_width (data_width)
    ) rsp_dispatcher_inst (
        .lcl_rd_data_valid (lcl_rd_data_valid),
        .lcl_rd_data       (lcl_rd_data),
        .lcl_rd_rsp        (lcl_rd_rsp),
        .lcl_rd_rsp_ready  (lcl_rd_rsp_ready),
        .dsc_rd_data_valid (dsc_rd_data_valid),
        .dsc_rd_data       (dsc_rd_data),
        .dsc_rd_rsp        (dsc_rd_rsp),
        .dsc_rd_rsp_ready  (dsc_rd_rsp_ready),
        .mm_rd_data_valid  (mm_rd_data_valid),
        .mm_rd_data        (mm_rd_data),
        .mm_rd_rsp         (mm_rd_rsp),
        .mm_rd_rsp_ready   (mm_rd_rsp_ready),
        .st_rd_data_valid  (st_rd_data_valid),
        .st_rd_data        (st_rd_data),
        .st_rd_rsp         (st_rd_rsp),
        .st_rd_rsp_ready   (st_rd_rsp_ready)
    );

endmodule

//--- odma_rd_arbiter_checker.sv
// Protocol assertions for the read arbiter top level
// Attached to every instance of the top level by bind

`timescale 1ns/100ps

module odma_rd_arbiter_checker (
    input logic clk,
    input logic resetn,
    input logic dsc_rd_ready,
    input logic mm_rd_ready,
    input logic st_rd_ready,
    input logic lcl_rd_valid,
    input logic dsc_rd_data_valid,
    input logic mm_rd_data_valid,
    input logic st_rd_data_valid
);

    // Only the holder may see ready
    ready_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({dsc_rd_ready, mm_rd_ready, st_rd_ready}))
        else $error("more than one engine ready at once");

    // Grant starts idle, so nothing is offered on the first cycle
    valid_after_reset: assert property (@(posedge clk)
        $rose(resetn) |-> !lcl_rd_valid)
        else $error("lcl_rd_valid high on the first cycle after reset");

    // A response beat reaches one engine at most
    data_valid_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({dsc_rd_data_valid, mm_rd_data_valid, st_rd_data_valid}))
        else $error("more than one engine sees a response beat");

endmodule

bind odma_rd_arbiter odma_rd_arbiter_checker checker_inst (
    .clk               (clk),
    .resetn            (resetn),
    .dsc_rd_ready      (dsc_rd_ready),
    .mm_rd_ready       (mm_rd_ready),
    .st_rd_ready       (st_rd_ready),
    .lcl_rd_valid      (lcl_rd_valid),
    .dsc_rd_data_valid (dsc_rd_data_valid),
    .mm_rd_data_valid  (mm_rd_data_valid),
    .st_rd_data_valid  (st_rd_data_valid)
);

//--- odma_rd_arbiter_clk_gen.sv
// Clock and reset source for the read arbiter testbench
// Free-running clock, reset held low for a fixed number of cycles

`timescale 1ns/100ps

module odma_rd_arbiter_clk_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release just after a rising edge, like the rest of the stimulus
    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #10;
        resetn = 1'b1;
    end

endmodule

//--- odma_rd_arbiter_tb.sv
// Directed testbench for the local read arbiter
// Covers request arbitration, back-pressure and response dispatch

`timescale 1ns/100ps

module odma_rd_arbiter_tb;

    localparam int data_width = 64;
    localparam int be_width   = data_width / 8;
    localparam int timeout    = 50;

    logic clk;
    logic resetn;

    // Engine side arrays indexed dsc = 0, mm = 1 and st = 2
    logic [2:0]            req_valid;
    odma_rd_pkg::rd_req_t  req_beat [3];
    logic [be_width-1:0]   req_be [3];
    wire  [2:0]            req_ready;
    wire  [2:0]            eng_valid;
    wire  [data_width-1:0] eng_data [3];
    wire odma_rd_pkg::rd_rsp_t eng_rsp [3];
    logic [2:0]            rsp_ready;

    // Interface side
    logic                  lcl_rd_valid;
    odma_rd_pkg::rd_req_t  lcl_rd_req;
    logic [be_width-1:0]   lcl_rd_be;
    logic                  lcl_rd_ready;
    logic                  lcl_rd_data_valid;
    logic [data_width-1:0] lcl_rd_data;
    odma_rd_pkg::rd_rsp_t  lcl_rd_rsp;
    logic                  lcl_rd_rsp_ready;

    logic [31:0] lcg_state;
    int          error_count;
    int          timeout_count;
    string       test_name;

    odma_rd_arbiter_clk_gen #(
        .period       (100),
        .reset_cycles (3)
    ) clk_gen_inst (
        .clk    (clk),
        .resetn (resetn)
    );

    odma_rd_arbiter #(
        .data_width (data_width)
    ) odma_rd_arbiter_inst (
        .clk               (clk),
        .resetn            (resetn),
        .lcl_rd_valid      (lcl_rd_valid),
        .lcl_rd_req        (lcl_rd_req),
        .lcl_rd_be         (lcl_rd_be),
        .lcl_rd_ready      (lcl_rd_ready),
        .lcl_rd_data_valid (lcl_rd_data_valid),
        .lcl_rd_data       (lcl_rd_data),
        .lcl_rd_rsp        (lcl_rd_rsp),
        .lcl_rd_rsp_ready  (lcl_rd_rsp_ready),
        .dsc_rd_valid      (req_valid[0]),
        .dsc_rd_req        (req_beat[0]),
        .dsc_rd_be         (req_be[0]),
        .dsc_rd_ready      (req_ready[0]),
        .dsc_rd_data_valid (eng_valid[0]),
        .dsc_rd_data       (eng_data[0]),
        .dsc_rd_rsp        (eng_rsp[0]),
        .dsc_rd_rsp_ready  (rsp_ready[0]),
        .mm_rd_valid       (req_valid[1]),
        .mm_rd_req         (req_beat[1]),
        .mm_rd_be          (req_be[1]),
        .mm_rd_ready       (req_ready[1]),
        .mm_rd_data_valid  (eng_valid[1]),
        .mm_rd_data        (eng_data[1]),
        .mm_rd_rsp         (eng_rsp[1]),
        .mm_rd_rsp_ready   (rsp_ready[1]),
        .st_rd_valid       (req_valid[2]),
        .st_rd_req         (req_beat[2]),
        .st_rd_be          (req_be[2]),
        .st_rd_ready       (req_ready[2]),
        .st_rd_data_valid  (eng_valid[2]),
        .st_rd_data        (eng_data[2]),
        .st_rd_rsp         (eng_rsp[2]),
        .st_rd_rsp_ready   (rsp_ready[2])
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Engine ID carried in the low AXI ID bits
    function automatic logic [2:0] id_of(input int eng);
        case (eng)
            0:       return odma_rd_pkg::dsc_engine_id;
            1:       return odma_rd_pkg::mm_engine_id;
            default: return odma_rd_pkg::st_engine_id;
        endcase
    endfunction

    // Engine index for an ID or -1 when nobody owns it
    function automatic int engine_of(input logic [2:0] id);
        case (id)
            3'd4:    return 0;
            3'd2:    return 1;
            3'd3:    return 2;
            default: return -1;
        endcase
    endfunction

    // Owner after a burst ends by the priority order of the finishing holder
    function automatic int next_holder(input int holder, input logic [2:0] valid);
        int order [3];
        case (holder)
            0:       order = '{1, 2, 0};
            1:       order = '{0, 2, 1};
            default: order = '{0, 1, 2};
        endcase
        for (int i = 0; i < 3; i++) begin
            if (valid[order[i]])
                return order[i];
        end
        return -1;
    endfunction

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic idle_cycles(input int n);
        req_valid = 3'b000;
        repeat (n) tick();
    endtask

    task automatic load_beat(input int eng, input int idx, input logic last);
        logic [31:0] r;
        r = next_rand();
        req_beat[eng].ea        = {next_rand(), next_rand()};
        req_beat[eng].axi_id    = {r[1:0], id_of(eng)};
        req_beat[eng].first     = (idx == 0);
        req_beat[eng].last      = last;
        req_beat[eng].ctx       = r[20:12];
        req_beat[eng].ctx_valid = r[31];
        req_be[eng]             = r[be_width+1:2];
        req_valid[eng]          = 1'b1;
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout in %s: gave up waiting for %s", test_name, what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_req(input string what, input odma_rd_pkg::rd_req_t exp,
                             input odma_rd_pkg::rd_req_t act);
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_rsp(input string what, input odma_rd_pkg::rd_rsp_t exp,
                             input odma_rd_pkg::rd_rsp_t act);
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: %s expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_vec(input string what, input logic [data_width-1:0] exp,
                             input logic [data_width-1:0] act);
        if (act !== exp) begin
            error_count++;
            $display("** Error %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // Accepts whatever is offered until every engine has dropped its request
    task automatic drain();
        int         wait_cnt;
        logic [2:0] acc;
        wait_cnt = 0;
        while (req_valid != 3'b000 && wait_cnt < timeout) begin
            #20;
            acc = req_ready & req_valid;
            tick();
            req_valid = req_valid & ~acc;
            wait_cnt++;
        end
        if (req_valid != 3'b000)
            report_timeout("engine requests to drain");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Request tests
    //////////////////////////////////////////////////////////////////////

    task automatic single_burst_test();
        int   beat;
        int   wait_cnt;
        logic accepted;
        test_name = "single_burst";
        beat = 0;
        wait_cnt = 0;
        load_beat(1, 0, 1'b0);
        while (beat < 3 && wait_cnt < timeout) begin
            #20;
            accepted = req_ready[1];
            check_bit("dsc_rd_ready", 1'b0, req_ready[0]);
            check_bit("st_rd_ready", 1'b0, req_ready[2]);
            if (accepted) begin
                check_bit("lcl_rd_valid", 1'b1, lcl_rd_valid);
                check_req("lcl_rd_req", req_beat[1], lcl_rd_req);
                check_vec("lcl_rd_be", req_be[1], lcl_rd_be);
            end
            tick();
            wait_cnt++;
            if (accepted) begin
                beat++;
                if (beat < 3)
                    load_beat(1, beat, beat == 2);
                else
                    req_valid[1] = 1'b0;
            end
        end
        if (beat < 3)
            report_timeout("the mm burst");
    endtask

    task automatic burst_hold_test();
        int   beat;
        int   wait_cnt;
        logic accepted;
        test_name = "burst_hold";
        beat = 0;
        wait_cnt = 0;
        load_beat(2, 0, 1'b0);
        while (beat < 4 && wait_cnt < timeout) begin
            #20;
            accepted = req_ready[2];
            check_bit("dsc_rd_ready during st burst", 1'b0, req_ready[0]);
            tick();
            wait_cnt++;
            if (accepted) begin
                beat++;
                // dsc joins while st is mid-burst
                if (beat == 1)
                    load_beat(0, 0, 1'b1);
                if (beat < 4)
                    load_beat(2, beat, beat == 3);
                else
                    req_valid[2] = 1'b0;
            end
        end
        if (beat < 4) begin
            report_timeout("the st burst");
        end else begin
            #20;
            check_bit("dsc_rd_ready after st burst", 1'b1, req_ready[0]);
            check_req("lcl_rd_req after st burst", req_beat[0], lcl_rd_req);
            tick();
        end
        drain();
    endtask

    task automatic priority_test();
        int         bursts [3];
        int         idx [3];
        int         expected;
        int         done_bursts;
        int         wait_cnt;
        int         acc;
        test_name = "priority";
        done_bursts = 0;
        wait_cnt = 0;
        expected = next_holder(-1, 3'b111);
        for (int e = 0; e < 3; e++) begin
            bursts[e] = 2;
            idx[e] = 0;
            load_beat(e, 0, 1'b0);
        end
        while (done_bursts < 6 && wait_cnt < timeout) begin
            #20;
            acc = -1;
            for (int e = 0; e < 3; e++) begin
                if (req_ready[e])
                    acc = e;
            end
            if (acc >= 0) begin
                for (int e = 0; e < 3; e++)
                    check_bit($sformatf("ready of engine %0d", e), e == expected, req_ready[e]);
                // Two beats per burst, so beat 1 ends it
                if (idx[acc] == 1) begin
                    bursts[acc]--;
                    done_bursts++;
                    expected = next_holder(acc, req_valid);
                end
            end
            tick();
            wait_cnt++;
            if (acc >= 0) begin
                if (idx[acc] == 1) begin
                    idx[acc] = 0;
                    if (bursts[acc] > 0)
                        load_beat(acc, 0, 1'b0);
                    else
                        req_valid[acc] = 1'b0;
                end else begin
                    idx[acc] = 1;
                    load_beat(acc, 1, 1'b1);
                end
            end
        end
        if (done_bursts < 6)
            report_timeout("all bursts of the three engines");
        req_valid = 3'b000;
    endtask

    task automatic backpressure_test();
        odma_rd_pkg::rd_req_t held;
        test_name = "backpressure";
        lcl_rd_ready = 1'b0;
        load_beat(1, 0, 1'b0);
        tick();
        load_beat(0, 0, 1'b1);
        load_beat(2, 0, 1'b1);
        held = req_beat[1];
        repeat (5) begin
            #20;
            check_bit("mm_rd_ready while stalled", 1'b0, req_ready[1]);
            check_bit("dsc_rd_ready while stalled", 1'b0, req_ready[0]);
            check_bit("st_rd_ready while stalled", 1'b0, req_ready[2]);
            check_bit("lcl_rd_valid while stalled", 1'b1, lcl_rd_valid);
            check_req("lcl_rd_req while stalled", held, lcl_rd_req);
            tick();
        end
        lcl_rd_ready = 1'b1;
        #20;
        check_bit("mm_rd_ready after stall", 1'b1, req_ready[1]);
        check_bit("dsc_rd_ready after stall", 1'b0, req_ready[0]);
        check_bit("st_rd_ready after stall", 1'b0, req_ready[2]);
        check_req("lcl_rd_req after stall", held, lcl_rd_req);
        tick();
        load_beat(1, 1, 1'b1);
        drain();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Response tests
    //////////////////////////////////////////////////////////////////////

    // Puts one response beat on the interface
    // Kind 3 gives an unknown ID
    task automatic drive_rsp(input int kind);
        logic [31:0] r;
        logic [2:0]  id;
        r = next_rand();
        if (kind < 3) begin
            id = id_of(kind);
        end else begin
            id = r[2:0];
            if (engine_of(id) >= 0)
                id = id ^ 3'b100;
        end
        lcl_rd_data_valid   = 1'b1;
        lcl_rd_data         = {next_rand(), next_rand()};
        lcl_rd_rsp.axi_id   = {r[4:3], id};
        lcl_rd_rsp.last     = r[5];
        lcl_rd_rsp.rsp_code = r[6];
    endtask

    task automatic rsp_dispatch_test();
        int match;
        test_name = "rsp_dispatch";
        rsp_ready = 3'b111;
        for (int i = 0; i < 12; i++) begin
            drive_rsp(i % 4);
            #20;
            match = engine_of(lcl_rd_rsp.axi_id[2:0]);
            for (int e = 0; e < 3; e++) begin
                check_bit($sformatf("valid of engine %0d", e), match == e, eng_valid[e]);
                check_vec($sformatf("data of engine %0d", e),
                          (match == e) ? lcl_rd_data : '0, eng_data[e]);
                check_rsp($sformatf("rsp of engine %0d", e),
                          (match == e) ? lcl_rd_rsp : '0, eng_rsp[e]);
            end
            check_bit("lcl_rd_rsp_ready", match >= 0, lcl_rd_rsp_ready);
            tick();
        end
        // Known ID without valid leaves all engines quiet
        drive_rsp(0);
        lcl_rd_data_valid = 1'b0;
        #20;
        for (int e = 0; e < 3; e++) begin
            check_bit($sformatf("idle valid of engine %0d", e), 1'b0, eng_valid[e]);
            check_vec($sformatf("idle data of engine %0d", e), '0, eng_data[e]);
        end
        tick();
    endtask

    task automatic rsp_ready_test();
        int match;
        test_name = "rsp_ready";
        for (int kind = 0; kind < 4; kind++) begin
            drive_rsp(kind);
            match = engine_of(lcl_rd_rsp.axi_id[2:0]);
            // sel 3 leaves every engine stalled
            for (int sel = 0; sel < 4; sel++) begin
                rsp_ready = (sel < 3) ? (3'b001 << sel) : 3'b000;
                #20;
                check_bit($sformatf("lcl_rd_rsp_ready, ready at engine %0d", sel),
                          (sel < 3) && (match == sel), lcl_rd_rsp_ready);
                tick();
            end
        end
        lcl_rd_data_valid = 1'b0;
        rsp_ready = 3'b111;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        lcg_state     = 32'he80f_dcba;
        error_count   = 0;
        timeout_count = 0;
        test_name     = "reset";
        req_valid     = 3'b000;
        for (int e = 0; e < 3; e++) begin
            req_beat[e] = '0;
            req_be[e]   = '0;
        end
        rsp_ready         = 3'b111;
        lcl_rd_ready      = 1'b1;
        lcl_rd_data_valid = 1'b0;
        lcl_rd_data       = '0;
        lcl_rd_rsp        = '0;

        @(posedge clk);
        for (int i = 0; i < timeout && resetn !== 1'b1; i++)
            @(posedge clk);
        #10;
        if (resetn !== 1'b1)
            report_timeout("reset release");
        #20;
        check_bit("lcl_rd_valid after reset", 1'b0, lcl_rd_valid);
        check_vec("engine ready after reset", '0, req_ready);
        tick();

        single_burst_test();
        idle_cycles(3);
        burst_hold_test();
        idle_cycles(3);
        priority_test();
        idle_cycles(3);
        backpressure_test();
        idle_cycles(3);
        rsp_dispatch_test();
        rsp_ready_test();
        idle_cycles(2);

        $display("Checks done with %0d errors and %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- odma_rd_pkg.sv
// Read-path definitions shared by the DMA read arbiter
// Widths, engine IDs, grant states and the request/response side structs

package odma_rd_pkg;

    //////////////////////////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////////////////////////

    localparam int axi_id_width = 5;
    localparam int ea_width     = 64;
    localparam int ctx_width    = 9;

    //////////////////////////////////////////////////////////////////////
    // Enumerations
    //////////////////////////////////////////////////////////////////////

    // Engine ID carried in the low three bits of the AXI ID
    // Values outside this set address no engine
    typedef enum logic [2:0] {
        mm_engine_id  = 3'd2,
        st_engine_id  = 3'd3,
        dsc_engine_id = 3'd4
    } engine_id_e;

    // Current owner of the local read request channel
    typedef enum logic [1:0] {
        grant_idle = 2'd0,
        grant_dsc  = 2'd1,
        grant_mm   = 2'd2,
        grant_st   = 2'd3
    } grant_e;

    //////////////////////////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////////////////////////

    // One request beat, without valid and byte enable (81 bits)
    typedef struct packed {
        logic [ea_width-1:0]     ea;
        logic [axi_id_width-1:0] axi_id;
        logic                    first;
        logic                    last;
        logic [ctx_width-1:0]    ctx;
        logic                    ctx_valid;
    } rd_req_t;

    // Side information of one response beat (7 bits)
    typedef struct packed {
        logic [axi_id_width-1:0] axi_id;
        logic                    last;
        logic                    rsp_code;
    } rd_rsp_t;

endpackage

//--- odma_rd_req_arbiter.sv
// Read request arbiter for the descriptor, MM and stream engines
// A registered grant picks one engine per burst; its beats and byte enables
// are steered to the local read interface and ready returns to it alone

`timescale 1ns/100ps

module odma_rd_req_arbiter #(
    parameter int data_width = 64
) (
    input  logic                       clk,
    input  logic                       resetn,

    // Engine request ports
    input  logic                       dsc_rd_valid,
    input  odma_rd_pkg::rd_req_t       dsc_rd_req,
    input  logic [data_width/8-1:0]    dsc_rd_be,
    output logic                       dsc_rd_ready,

    input  logic                       mm_rd_valid,
    input  odma_rd_pkg::rd_req_t       mm_rd_req,
    input  logic [data_width/8-1:0]    mm_rd_be,
    output logic                       mm_rd_ready,

    input  logic                       st_rd_valid,
    input  odma_rd_pkg::rd_req_t       st_rd_req,
    input  logic [data_width/8-1:0]    st_rd_be,
    output logic                       st_rd_ready,

    // Local read request channel
    output logic                       lcl_rd_valid,
    output odma_rd_pkg::rd_req_t       lcl_rd_req,
    output logic [data_width/8-1:0]    lcl_rd_be,
    input  logic                       lcl_rd_ready
);

    odma_rd_pkg::grant_e grant_q;
    odma_rd_pkg::grant_e grant_d;
    logic                hold_q;
    logic [3:0]          req_vec;
    logic                other_req;
    logic                arb_due;

    // First requesting engine in the order p0, p1, p2, else idle
    function automatic odma_rd_pkg::grant_e pick(
        input odma_rd_pkg::grant_e p0,
        input odma_rd_pkg::grant_e p1,
        input odma_rd_pkg::grant_e p2,
        input logic [3:0]          req
    );
        if (req[p0])
            return p0;
        else if (req[p1])
            return p1;
        else if (req[p2])
            return p2;
        else
            return odma_rd_pkg::grant_idle;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Grant control
    //////////////////////////////////////////////////////////////////////

    // Request vector indexed by grant value; bit 0 stands for idle
    assign req_vec = {st_rd_valid, mm_rd_valid, dsc_rd_valid, 1'b0};

    // Someone other than the current holder wants the channel
    assign other_req = |(req_vec & ~(4'b0001 << grant_q));

    // Free channel, or the holder's last beat goes out this cycle
    assign arb_due = (grant_q == odma_rd_pkg::grant_idle) ||
                     (lcl_rd_valid && lcl_rd_req.last && lcl_rd_ready);

    always_comb begin
        grant_d = grant_q;
        if (arb_due) begin
            case (grant_q)
                odma_rd_pkg::grant_dsc:
                    grant_d = pick(odma_rd_pkg::grant_mm, odma_rd_pkg::grant_st,
                                   odma_rd_pkg::grant_dsc, req_vec);
                odma_rd_pkg::grant_mm:
                    grant_d = pick(odma_rd_pkg::grant_dsc, odma_rd_pkg::grant_st,
                                   odma_rd_pkg::grant_mm, req_vec);
                odma_rd_pkg::grant_st:
                    grant_d = pick(odma_rd_pkg::grant_dsc, odma_rd_pkg::grant_mm,
                                   odma_rd_pkg::grant_st, req_vec);
                default:
                    grant_d = pick(odma_rd_pkg::grant_dsc, odma_rd_pkg::grant_mm,
                                   odma_rd_pkg::grant_st, req_vec);
            endcase
        end else if (hold_q) begin
            // Lone finisher keeps first claim until a new request shows up
            case (grant_q)
                odma_rd_pkg::grant_dsc:
                    grant_d = pick(odma_rd_pkg::grant_dsc, odma_rd_pkg::grant_mm,
                                   odma_rd_pkg::grant_st, req_vec);
                odma_rd_pkg::grant_mm:
                    grant_d = pick(odma_rd_pkg::grant_mm, odma_rd_pkg::grant_dsc,
                                   odma_rd_pkg::grant_st, req_vec);
                odma_rd_pkg::grant_st:
                    grant_d = pick(odma_rd_pkg::grant_st, odma_rd_pkg::grant_dsc,
                                   odma_rd_pkg::grant_mm, req_vec);
                default:
                    grant_d = grant_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            grant_q <= odma_rd_pkg::grant_idle;
            hold_q  <= 1'b0;
        end else begin
            grant_q <= grant_d;
            if (arb_due && !other_req)
                hold_q <= 1'b1;
            else if (hold_q && (|req_vec))
                hold_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request steering
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (grant_q)
            odma_rd_pkg::grant_dsc: begin
                lcl_rd_valid = dsc_rd_valid;
                lcl_rd_req   = dsc_rd_req;
                lcl_rd_be    = dsc_rd_be;
            end
            odma_rd_pkg::grant_mm: begin
                lcl_rd_valid = mm_rd_valid;
                lcl_rd_req   = mm_rd_req;
                lcl_rd_be    = mm_rd_be;
            end
            odma_rd_pkg::grant_st: begin
                lcl_rd_valid = st_rd_valid;
                lcl_rd_req   = st_rd_req;
                lcl_rd_be    = st_rd_be;
            end
            default: begin
                lcl_rd_valid = 1'b0;
                lcl_rd_req   = '0;
                lcl_rd_be    = '0;
            end
        endcase
    end

    // Ready only reaches the holder
    assign dsc_rd_ready = lcl_rd_ready && (grant_q == odma_rd_pkg::grant_dsc);
    assign mm_rd_ready  = lcl_rd_ready && (grant_q == odma_rd_pkg::grant_mm);
    assign st_rd_ready  = lcl_rd_ready && (grant_q == odma_rd_pkg::grant_st);

endmodule

//--- odma_rd_rsp_dispatcher.sv
// Read response dispatcher
// Sends each response beat to the engine named by its AXI ID and returns
// that engine's ready to the local read interface

`timescale 1ns/100ps

module odma_rd_rsp_dispatcher #(
    parameter int data_width = 64
) (
    // Local read response channel
    input  logic                       lcl_rd_data_valid,
    input  logic [data_width-1:0]      lcl_rd_data,
    input  odma_rd_pkg::rd_rsp_t       lcl_rd_rsp,
    output logic                       lcl_rd_rsp_ready,

    // Engine response ports
    output logic                       dsc_rd_data_valid,
    output logic [data_width-1:0]      dsc_rd_data,
    output odma_rd_pkg::rd_rsp_t       dsc_rd_rsp,
    input  logic                       dsc_rd_rsp_ready,

    output logic                       mm_rd_data_valid,
    output logic [data_width-1:0]      mm_rd_data,
    output odma_rd_pkg::rd_rsp_t       mm_rd_rsp,
    input  logic                       mm_rd_rsp_ready,

    output logic                       st_rd_data_valid,
    output logic [data_width-1:0]      st_rd_data,
    output odma_rd_pkg::rd_rsp_t       st_rd_rsp,
    input  logic                       st_rd_rsp_ready
);

    odma_rd_pkg::engine_id_e eng_id;
    logic                    hit_dsc;
    logic                    hit_mm;
    logic                    hit_st;

    assign eng_id  = odma_rd_pkg::engine_id_e'(lcl_rd_rsp.axi_id[2:0]);
    assign hit_dsc = (eng_id == odma_rd_pkg::dsc_engine_id);
    assign hit_mm  = (eng_id == odma_rd_pkg::mm_engine_id);
    assign hit_st  = (eng_id == odma_rd_pkg::st_engine_id);

    // Unknown IDs match nobody, so their ready stays low
    assign lcl_rd_rsp_ready = (hit_dsc && dsc_rd_rsp_ready) ||
                              (hit_mm  && mm_rd_rsp_ready)  ||
                              (hit_st  && st_rd_rsp_ready);

    //////////////////////////////////////////////////////////////////////
    // Per-engine beat outputs, zero unless addressed and valid
    //////////////////////////////////////////////////////////////////////

    assign dsc_rd_data_valid = lcl_rd_data_valid && hit_dsc;
    assign dsc_rd_data       = dsc_rd_data_valid ? lcl_rd_data : '0;
    assign dsc_rd_rsp        = dsc_rd_data_valid ? lcl_rd_rsp : '0;

    assign mm_rd_data_valid  = lcl_rd_data_valid && hit_mm;
    assign mm_rd_data        = mm_rd_data_valid ? lcl_rd_data : '0;
    assign mm_rd_rsp         = mm_rd_data_valid ? lcl_rd_rsp : '0;

    assign st_rd_data_valid  = lcl_rd_data_valid && hit_st;
    assign st_rd_data        = st_rd_data_valid ? lcl_rd_data : '0;
    assign st_rd_rsp         = st_rd_data_valid ? lcl_rd_rsp : '0;

endmodule
